//--- logic/core_cfg_pkg.sv
package core_cfg_pkg;

  // Datapath and register file
  localparam int DATA_WIDTH = 32;
  localparam int REG_COUNT  = 32;

  typedef logic [DATA_WIDTH-1:0]        data_t;
  typedef logic [$clog2(REG_COUNT)-1:0] reg_id_t;

  // Default sizes of the back end
  localparam int DEFAULT_ROB_ENTRIES = 4;
  localparam int DEFAULT_MUL_STAGES  = 5;

endpackage

//--- logic/alu_op_pkg.sv
package alu_op_pkg;

  typedef logic [2:0] alu_op_t;

  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_SUB = 3'd1;
  localparam alu_op_t OP_AND = 3'd2;
  localparam alu_op_t OP_OR  = 3'd3;
  localparam alu_op_t OP_XOR = 3'd4;
  // Shift amount from the low bits of b
  localparam alu_op_t OP_SLL = 3'd5;
  localparam alu_op_t OP_SRL = 3'd6;
  // Low half of the product, runs in the multiply pipe
  localparam alu_op_t OP_MUL = 3'd7;

endpackage

//--- logic/issue_if.sv
`timescale 1ns/1ps

interface issue_if #(
  parameter int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES
);

  localparam int TAG_W = $clog2(ROB_ENTRIES);

  // One-cycle strobes, one per execution unit
  logic                  alu_valid;
  logic                  mul_valid;
  alu_op_pkg::alu_op_t   op;
  core_cfg_pkg::data_t   a;
  core_cfg_pkg::data_t   b;
  logic [TAG_W-1:0]      tag;

  modport issuer (output alu_valid, mul_valid, op, a, b, tag);
  modport alu    (input alu_valid, op, a, b, tag);
  modport mul    (input mul_valid, a, b, tag);

endinterface

//--- logic/issue_unit.sv
`timescale 1ns/1ps

module issue_unit #(
  parameter  int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  localparam int TAG_W       = $clog2(ROB_ENTRIES)
) (
  input  logic                  op_valid_i,
  input  alu_op_pkg::alu_op_t   op_i,
  input  core_cfg_pkg::data_t   a_i,
  input  core_cfg_pkg::data_t   b_i,
  input  core_cfg_pkg::reg_id_t dest_i,
  input  logic                  rob_full_i,
  input  logic [TAG_W-1:0]      new_tag_i,
  input  logic                  alu_busy_i,
  output logic                  op_ready_o,
  output logic                  alloc_valid_o,
  output core_cfg_pkg::reg_id_t alloc_reg_o,
  issue_if.issuer               issue
);

  logic accept;
  logic is_mul;

  // Stall on a full ROB or a stuck ALU result
  assign op_ready_o = !rob_full_i && !alu_busy_i;
  assign accept     = op_valid_i && op_ready_o;
  assign is_mul     = (op_i == alu_op_pkg::OP_MUL);

  assign issue.alu_valid = accept && !is_mul;
  assign issue.mul_valid = accept && is_mul;
  assign issue.op        = op_i;
  assign issue.a         = a_i;
  assign issue.b         = b_i;
  assign issue.tag       = new_tag_i;

  // ROB entry taken on the same edge
  assign alloc_valid_o = accept;
  assign alloc_reg_o   = dest_i;

endmodule

//--- logic/alu_stage.sv
`timescale 1ns/1ps

module alu_stage #(
  parameter  int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  localparam int TAG_W       = $clog2(ROB_ENTRIES)
) (
  input  logic                clk_i,
  input  logic                rst_i,
  issue_if.alu                issue,
  input  logic                grant_i,
  output logic                valid_o,
  output logic [TAG_W-1:0]    tag_o,
  output core_cfg_pkg::data_t result_o,
  output logic                busy_o
);

  localparam int SHAMT_W = $clog2(core_cfg_pkg::DATA_WIDTH);

  logic                valid_q;
  logic [TAG_W-1:0]    tag_q;
  alu_op_pkg::alu_op_t op_q;
  core_cfg_pkg::data_t a_q;
  core_cfg_pkg::data_t b_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (issue.alu_valid) begin
      valid_q <= 1'b1;
    end else if (grant_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue.alu_valid) begin
      tag_q <= issue.tag;
      op_q  <= issue.op;
      a_q   <= issue.a;
      b_q   <= issue.b;
    end
  end

  always_comb begin
    case (op_q)
      alu_op_pkg::OP_ADD: result_o = a_q + b_q;
      alu_op_pkg::OP_SUB: result_o = a_q - b_q;
      alu_op_pkg::OP_AND: result_o = a_q & b_q;
      alu_op_pkg::OP_OR:  result_o = a_q | b_q;
      alu_op_pkg::OP_XOR: result_o = a_q ^ b_q;
      alu_op_pkg::OP_SLL: result_o = a_q << b_q[SHAMT_W-1:0];
      alu_op_pkg::OP_SRL: result_o = a_q >> b_q[SHAMT_W-1:0];
      default:            result_o = '0;
    endcase
  end

  assign valid_o = valid_q;
  assign tag_o   = tag_q;
  // Result lost arbitration, hold it another cycle
  assign busy_o  = valid_q && !grant_i;

endmodule

//--- logic/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe #(
  parameter  int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  parameter  int MUL_STAGES  = core_cfg_pkg::DEFAULT_MUL_STAGES,
  localparam int TAG_W       = $clog2(ROB_ENTRIES)
) (
  input  logic                clk_i,
  input  logic                rst_i,
  issue_if.mul                issue,
  output logic                valid_o,
  output logic [TAG_W-1:0]    tag_o,
  output core_cfg_pkg::data_t result_o
);

  logic                valid_q [MUL_STAGES];
  logic [TAG_W-1:0]    tag_q   [MUL_STAGES];
  core_cfg_pkg::data_t prod_q  [MUL_STAGES];
  core_cfg_pkg::data_t product;

  // Low half only
  assign product = issue.a * issue.b;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= issue.mul_valid;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload moves every cycle, the pipe never stalls
  always_ff @(posedge clk_i) begin
    tag_q[0]  <= issue.tag;
    prod_q[0] <= product;
    for (int i = 1; i < MUL_STAGES; i++) begin
      tag_q[i]  <= tag_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign valid_o  = valid_q[MUL_STAGES-1];
  assign tag_o    = tag_q[MUL_STAGES-1];
  assign result_o = prod_q[MUL_STAGES-1];

endmodule

//--- logic/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter #(
  parameter  int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  localparam int TAG_W       = $clog2(ROB_ENTRIES)
) (
  input  logic                alu_valid_i,
  input  logic [TAG_W-1:0]    alu_tag_i,
  input  core_cfg_pkg::data_t alu_result_i,
  input  logic                mul_valid_i,
  input  logic [TAG_W-1:0]    mul_tag_i,
  input  core_cfg_pkg::data_t mul_result_i,
  output logic                alu_grant_o,
  output logic                complete_valid_o,
  output logic [TAG_W-1:0]    complete_tag_o,
  output core_cfg_pkg::data_t complete_data_o
);

  // Multiply pipe cannot stall, so it always wins
  assign alu_grant_o      = alu_valid_i && !mul_valid_i;
  assign complete_valid_o = alu_valid_i || mul_valid_i;
  assign complete_tag_o   = mul_valid_i ? mul_tag_i : alu_tag_i;
  assign complete_data_o  = mul_valid_i ? mul_result_i : alu_result_i;

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
  parameter  int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  localparam int TAG_W       = $clog2(ROB_ENTRIES)
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  alloc_valid_i,
  input  core_cfg_pkg::reg_id_t alloc_reg_i,
  input  logic                  complete_valid_i,
  input  logic [TAG_W-1:0]      complete_tag_i,
  input  core_cfg_pkg::data_t   complete_data_i,
  output logic                  full_o,
  output logic [TAG_W-1:0]      new_tag_o,
  output logic                  commit_valid_o,
  output core_cfg_pkg::reg_id_t commit_reg_o,
  output core_cfg_pkg::data_t   commit_data_o
);

  localparam int CNT_W = $clog2(ROB_ENTRIES + 1);

  logic [TAG_W-1:0]       head_q;
  logic [TAG_W-1:0]       tail_q;
  logic [CNT_W-1:0]       count_q;
  logic [ROB_ENTRIES-1:0] busy_q;
  logic [ROB_ENTRIES-1:0] done_q;

  core_cfg_pkg::reg_id_t  dest_q [ROB_ENTRIES];
  core_cfg_pkg::data_t    data_q [ROB_ENTRIES];

  logic alloc;
  logic commit;

  // Full is judged on the current count, a same-cycle commit does not help
  assign full_o    = (count_q == CNT_W'(ROB_ENTRIES));
  assign new_tag_o = tail_q;
  assign alloc     = alloc_valid_i && !full_o;
  assign commit    = busy_q[head_q] && done_q[head_q];

  assign commit_valid_o = commit;
  assign commit_reg_o   = dest_q[head_q];
  assign commit_data_o  = data_q[head_q];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      busy_q  <= '0;
      done_q  <= '0;
    end else begin
      if (commit) begin
        busy_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end

      if (complete_valid_i) begin
        done_q[complete_tag_i] <= 1'b1;
      end

      // Tail never equals head of a live entry here
      if (alloc) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end

      case ({alloc, commit})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      dest_q[tail_q] <= alloc_reg_i;
    end
    if (complete_valid_i) begin
      data_q[complete_tag_i] <= complete_data_i;
    end
  end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  wr_en_i,
  input  core_cfg_pkg::reg_id_t wr_reg_i,
  input  core_cfg_pkg::data_t   wr_data_i,
  input  core_cfg_pkg::reg_id_t rd_reg_i,
  output core_cfg_pkg::data_t   rd_data_o
);

  core_cfg_pkg::data_t regs_q [core_cfg_pkg::REG_COUNT];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < core_cfg_pkg::REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (wr_reg_i != '0)) begin
      // x0 stays zero
      regs_q[wr_reg_i] <= wr_data_i;
    end
  end

  assign rd_data_o = regs_q[rd_reg_i];

endmodule

//--- logic/cpu_backend.sv
`timescale 1ns/1ps

module cpu_backend #(
  parameter int ROB_ENTRIES = core_cfg_pkg::DEFAULT_ROB_ENTRIES,
  parameter int MUL_STAGES  = core_cfg_pkg::DEFAULT_MUL_STAGES
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  op_valid_i,
  input  alu_op_pkg::alu_op_t   op_i,
  input  core_cfg_pkg::data_t   a_i,
  input  core_cfg_pkg::data_t   b_i,
  input  core_cfg_pkg::reg_id_t dest_i,
  input  core_cfg_pkg::reg_id_t rd_reg_i,
  output logic                  op_ready_o,
  output logic                  commit_valid_o,
  output core_cfg_pkg::reg_id_t commit_reg_o,
  output core_cfg_pkg::data_t   commit_data_o,
  output core_cfg_pkg::data_t   rd_data_o
);

  localparam int TAG_W = $clog2(ROB_ENTRIES);

  // Issue side
  logic                  rob_full;
  logic [TAG_W-1:0]      rob_new_tag;
  logic                  alloc_valid;
  core_cfg_pkg::reg_id_t alloc_reg;

  // ALU result
  logic                  alu_valid;
  logic                  alu_busy;
  logic                  alu_grant;
  logic [TAG_W-1:0]      alu_tag;
  core_cfg_pkg::data_t   alu_result;

  // Multiply result
  logic                  mul_valid;
  logic [TAG_W-1:0]      mul_tag;
  core_cfg_pkg::data_t   mul_result;

  // Completion into the ROB
  logic                  complete_valid;
  logic [TAG_W-1:0]      complete_tag;
  core_cfg_pkg::data_t   complete_data;

  issue_if #(.ROB_ENTRIES(ROB_ENTRIES)) issue_bus ();

  issue_unit #(.ROB_ENTRIES(ROB_ENTRIES)) issue (
    .op_valid_i    (op_valid_i),
    .op_i          (op_i),
    .a_i           (a_i),
    .b_i           (b_i),
    .dest_i        (dest_i),
    .rob_full_i    (rob_full),
    .new_tag_i     (rob_new_tag),
    .alu_busy_i    (alu_busy),
    .op_ready_o    (op_ready_o),
    .alloc_valid_o (alloc_valid),
    .alloc_reg_o   (alloc_reg),
    .issue         (issue_bus.issuer)
  );

  alu_stage #(.ROB_ENTRIES(ROB_ENTRIES)) alu (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue    (issue_bus.alu),
    .grant_i  (alu_grant),
    .valid_o  (alu_valid),
    .tag_o    (alu_tag),
    .result_o (alu_result),
    .busy_o   (alu_busy)
  );

  mul_pipe #(
    .ROB_ENTRIES (ROB_ENTRIES),
    .MUL_STAGES  (MUL_STAGES)
  ) mul (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue    (issue_bus.mul),
    .valid_o  (mul_valid),
    .tag_o    (mul_tag),
    .result_o (mul_result)
  );

  wb_arbiter #(.ROB_ENTRIES(ROB_ENTRIES)) wb_arb (
    .alu_valid_i      (alu_valid),
    .alu_tag_i        (alu_tag),
    .alu_result_i     (alu_result),
    .mul_valid_i      (mul_valid),
    .mul_tag_i        (mul_tag),
    .mul_result_i     (mul_result),
    .alu_grant_o      (alu_grant),
    .complete_valid_o (complete_valid),
    .complete_tag_o   (complete_tag),
    .complete_data_o  (complete_data)
  );

  reorder_buffer #(.ROB_ENTRIES(ROB_ENTRIES)) rob (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .alloc_valid_i    (alloc_valid),
    .alloc_reg_i      (alloc_reg),
    .complete_valid_i (complete_valid),
    .complete_tag_i   (complete_tag),
    .complete_data_i  (complete_data),
    .full_o           (rob_full),
    .new_tag_o        (rob_new_tag),
    .commit_valid_o   (commit_valid_o),
    .commit_reg_o     (commit_reg_o),
    .commit_data_o    (commit_data_o)
  );

  // Commits also write the architectural state
  register_file arch_file (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (commit_valid_o),
    .wr_reg_i  (commit_reg_o),
    .wr_data_i (commit_data_o),
    .rd_reg_i  (rd_reg_i),
    .rd_data_o (rd_data_o)
  );

endmodule

//--- tests/cpu_backend_chk.sv
`timescale 1ns/1ps

module cpu_backend_chk (
  input logic clk_i,
  input logic rst_i,
  input logic op_ready_i,
  input logic commit_valid_i
);

  // Control outputs stay known outside reset
  assert property (@(posedge clk_i) disable iff (!rst_i) !$isunknown(op_ready_i))
    else $error("op_ready_o is unknown while out of reset");

  assert property (@(posedge clk_i) disable iff (!rst_i) !$isunknown(commit_valid_i))
    else $error("commit_valid_o is unknown while out of reset");

  // First cycle after reset release
  assert property (@(posedge clk_i) $rose(rst_i) |-> !commit_valid_i)
    else $error("commit_valid_o high in the first cycle after reset");

  assert property (@(posedge clk_i) $rose(rst_i) |-> op_ready_i)
    else $error("op_ready_o low in the first cycle after reset");

endmodule

bind cpu_backend cpu_backend_chk chk (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .op_ready_i     (op_ready_o),
  .commit_valid_i (commit_valid_o)
);

//--- tests/cpu_backend_tb.sv
`timescale 1ns/1ps

module cpu_backend_tb;

  localparam int ROB_ENTRIES = 4;
  localparam int MUL_STAGES  = 5;
  localparam int N_ALU       = 20;
  localparam int N_MIX       = 30;
  localparam int N_PAIRS     = 3;
  localparam int N_BURST     = 8;
  localparam int NUM_OPS     = N_ALU + 2 + N_MIX + 2 * N_PAIRS + N_BURST;

  logic                  clk_i;
  logic                  rst_i;
  logic                  op_valid_i;
  alu_op_pkg::alu_op_t   op_i;
  core_cfg_pkg::data_t   a_i;
  core_cfg_pkg::data_t   b_i;
  core_cfg_pkg::reg_id_t dest_i;
  core_cfg_pkg::reg_id_t rd_reg_i;
  logic                  op_ready_o;
  logic                  commit_valid_o;
  core_cfg_pkg::reg_id_t commit_reg_o;
  core_cfg_pkg::data_t   commit_data_o;
  core_cfg_pkg::data_t   rd_data_o;

  int seed         = 11302;
  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int accepted_cnt = 0;
  int commit_cnt   = 0;
  int inflight     = 0;
  bit stall_seen;

  core_cfg_pkg::reg_id_t exp_reg_q[$];
  core_cfg_pkg::data_t   exp_data_q[$];
  core_cfg_pkg::data_t   model_regs[core_cfg_pkg::REG_COUNT];

  cpu_backend #(
    .ROB_ENTRIES (ROB_ENTRIES),
    .MUL_STAGES  (MUL_STAGES)
  ) UUT (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .op_valid_i     (op_valid_i),
    .op_i           (op_i),
    .a_i            (a_i),
    .b_i            (b_i),
    .dest_i         (dest_i),
    .rd_reg_i       (rd_reg_i),
    .op_ready_o     (op_ready_o),
    .commit_valid_o (commit_valid_o),
    .commit_reg_o   (commit_reg_o),
    .commit_data_o  (commit_data_o),
    .rd_data_o      (rd_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic core_cfg_pkg::data_t expected_result(input alu_op_pkg::alu_op_t op,
                                                          input core_cfg_pkg::data_t a,
                                                          input core_cfg_pkg::data_t b);
    logic [63:0] wide;
    wide = {32'd0, a} * {32'd0, b};
    case (op)
      alu_op_pkg::OP_ADD: return a + b;
      alu_op_pkg::OP_SUB: return a - b;
      alu_op_pkg::OP_AND: return a & b;
      alu_op_pkg::OP_OR:  return a | b;
      alu_op_pkg::OP_XOR: return a ^ b;
      alu_op_pkg::OP_SLL: return a << b[4:0];
      alu_op_pkg::OP_SRL: return a >> b[4:0];
      default:            return wide[31:0];
    endcase
  endfunction

  // Holds the operation until the DUT takes it
  task automatic issue_op(input alu_op_pkg::alu_op_t op, input core_cfg_pkg::data_t a,
                          input core_cfg_pkg::data_t b, input core_cfg_pkg::reg_id_t dest);
    bit taken;
    taken = 1'b0;
    @(negedge clk_i);
    op_valid_i = 1'b1;
    op_i       = op;
    a_i        = a;
    b_i        = b;
    dest_i     = dest;
    while (!taken) begin
      @(posedge clk_i);
      if (op_ready_o) begin
        taken = 1'b1;
        exp_reg_q.push_back(dest);
        exp_data_q.push_back(expected_result(op, a, b));
        accepted_cnt++;
      end else begin
        stall_seen = 1'b1;
      end
    end
  endtask

  task automatic issue_random(input bit alu_only);
    int                  r;
    alu_op_pkg::alu_op_t op;
    r = $random(seed);
    if (alu_only) begin
      op = alu_op_pkg::alu_op_t'($unsigned(r) % 7);
    end else begin
      op = r[2:0];
    end
    issue_op(op, $random(seed), $random(seed), r[12:8]);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_i);
      op_valid_i = 1'b0;
      @(posedge clk_i);
    end
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    op_valid_i = 1'b0;
    while (exp_reg_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  // Compare process, commits against the expected queue
  always @(posedge clk_i) begin
    core_cfg_pkg::reg_id_t reg_e;
    core_cfg_pkg::data_t   data_e;
    if (rst_i) begin
      if (op_valid_i && op_ready_o) begin
        inflight++;
      end
      if (commit_valid_o) begin
        inflight--;
        commit_cnt++;
        if (exp_reg_q.size() == 0) begin
          $display("Commit to register %0d at %0t with no operation outstanding",
                   commit_reg_o, $time);
          other_cnt++;
        end else begin
          reg_e  = exp_reg_q.pop_front();
          data_e = exp_data_q.pop_front();
          if (commit_reg_o !== reg_e) begin
            $display("MISMATCH %0t: commit register %0d, expected %0d",
                     $time, commit_reg_o, reg_e);
            mismatch_cnt++;
          end
          if (commit_data_o !== data_e) begin
            $display("MISMATCH %0t: commit data %h, expected %h",
                     $time, commit_data_o, data_e);
            mismatch_cnt++;
          end
          if (reg_e != '0) begin
            model_regs[reg_e] = data_e;
          end
        end
      end
      if (inflight > ROB_ENTRIES) begin
        $display("More than %0d operations in flight at %0t", ROB_ENTRIES, $time);
        other_cnt++;
      end
    end
  end

  initial begin
    repeat (NUM_OPS * 20 + 200) @(posedge clk_i);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_i      = 1'b0;
    op_valid_i = 1'b0;
    op_i       = alu_op_pkg::OP_ADD;
    a_i        = '0;
    b_i        = '0;
    dest_i     = '0;
    rd_reg_i   = '0;
    stall_seen = 1'b0;
    for (int i = 0; i < core_cfg_pkg::REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;

    // ALU stream, two results aimed at x0
    issue_op(alu_op_pkg::OP_ADD, 32'd5, 32'd7, 5'd0);
    for (int i = 0; i < N_ALU; i++) begin
      issue_random(1'b1);
    end
    issue_op(alu_op_pkg::OP_XOR, 32'hdead_beef, 32'h1234_5678, 5'd0);
    wait_drain();

    for (int i = 0; i < N_MIX; i++) begin
      issue_random(1'b0);
    end
    wait_drain();

    // Multiply and ALU reach writeback in the same cycle
    for (int p = 0; p < N_PAIRS; p++) begin
      issue_op(alu_op_pkg::OP_MUL, $random(seed), $random(seed),
               core_cfg_pkg::reg_id_t'(p + 1));
      idle_cycles(MUL_STAGES - 2);
      issue_op(alu_op_pkg::OP_SUB, $random(seed), $random(seed),
               core_cfg_pkg::reg_id_t'(p + 10));
      wait_drain();
    end

    stall_seen = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      issue_op(alu_op_pkg::OP_MUL, $random(seed), $random(seed),
               core_cfg_pkg::reg_id_t'(20 + i));
    end
    wait_drain();
    if (!stall_seen) begin
      $display("op_ready_o never went low during the multiply burst");
      other_cnt++;
    end

    for (int r = 0; r < core_cfg_pkg::REG_COUNT; r++) begin
      @(negedge clk_i);
      rd_reg_i = core_cfg_pkg::reg_id_t'(r);
      @(posedge clk_i);
      if (rd_data_o !== model_regs[r]) begin
        $display("MISMATCH %0t: register %0d reads %h, expected %h",
                 $time, r, rd_data_o, model_regs[r]);
        mismatch_cnt++;
      end
    end

    if (exp_reg_q.size() != 0) begin
      $display("%0d operations were never committed", exp_reg_q.size());
      other_cnt++;
    end
    if (commit_cnt != accepted_cnt) begin
      $display("Accepted %0d operations but saw %0d commits", accepted_cnt, commit_cnt);
      other_cnt++;
    end

    $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- cpu_backend.f
logic/core_cfg_pkg.sv
logic/alu_op_pkg.sv
logic/issue_if.sv
logic/issue_unit.sv
logic/alu_stage.sv
logic/mul_pipe.sv
logic/wb_arbiter.sv
logic/reorder_buffer.sv
logic/register_file.sv
logic/cpu_backend.sv
tests/cpu_backend_chk.sv
tests/cpu_backend_tb.sv
